/* verilog/elink_pkg.sv */
`default_nettype none

package elink_pkg;

   //##################################################
   // mesh geometry
   //##################################################
   localparam int AW = 32;                 // address and data width of the mesh

   // dstaddr field positions
   localparam int GROUP_MSB  = 19;         // group select
   localparam int GROUP_LSB  = 16;
   localparam int BLOCK_MSB  = 10;         // block inside the mmr group
   localparam int BLOCK_LSB  = 8;
   localparam int REG_MSB    = 7;          // word index inside a block
   localparam int REG_LSB    = 2;
   localparam int MB_SEL_BIT = 5;          // mailbox select inside the rx block

   //##################################################
   // packet format
   //##################################################
   // 104 bits, msb first
   typedef struct packed {
      logic          write;                // 1 = write, 0 = read
      logic [1:0]    datamode;
      logic [4:0]    ctrlmode;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
      logic [AW-1:0] data;
   } elink_packet_t;

   //##################################################
   // address codes
   //##################################################
   typedef enum logic [3:0] {
      EGROUP_MMR = 4'hF                    // memory mapped registers
   } egroup_e;

   typedef enum logic [2:0] {
      EBLOCK_RX  = 3'd1,
      EBLOCK_DMA = 3'd5
   } eblock_e;

   // indices stay below 8 since bit 5 picks the mailbox
   typedef enum logic [5:0] {
      ERX_CFG      = 6'd0,
      ERX_STATUS   = 6'd1,
      ERX_GPIO     = 6'd2,
      ERX_OFFSET   = 6'd3,
      ERX_IDELAY0  = 6'd4,
      ERX_IDELAY1  = 6'd5,
      ERX_TESTDATA = 6'd6
   } erx_reg_e;

   // static fields of the rx mode register
   typedef struct packed {
      logic          test_mode;            // bit 0
      logic          mmu_enable;           // bit 1
      logic [1:0]    remap_mode;           // bits 3:2
      logic [11:0]   remap_sel;            // bits 15:4
      logic [11:0]   remap_pattern;        // bits 27:16
      logic          mailbox_irq_en;       // bit 28
   } erx_cfg_t;

endpackage

`default_nettype wire

/* verilog/erx_dma_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_dma_regs
  (
   input  wire                     clk,
   input  wire                     nreset,
   input  wire                     dma_access,
   input  wire                     acc_write,
   input  wire [1:0]               acc_addr,       // word select
   input  wire [elink_pkg::AW-1:0] acc_data,
   output logic [elink_pkg::AW-1:0] dma_rdata
  );

   import elink_pkg::*;

   logic [AW-1:0] regs [4];                // store and read back only

   //##################################################
   // register file
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < 4; i++)
            regs[i] <= '0;
      end
      else if (dma_access && acc_write)
      begin
         regs[acc_addr] <= acc_data;
      end
   end

   // registered readback, zero when idle
   always_ff @(posedge clk)
   begin
      if (dma_access && !acc_write)
         dma_rdata <= regs[acc_addr];
      else
         dma_rdata <= '0;
   end

endmodule

`default_nettype wire

/* verilog/erx_mailbox.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_mailbox
  #(
   parameter int MB_DEPTH = 4              // power of two, at least 2
  )
  (
   input  wire                     clk,
   input  wire                     nreset,
   input  wire                     mailbox_access,
   input  wire                     acc_write,      // 1 push, 0 pop
   input  wire [elink_pkg::AW-1:0] acc_data,
   input  wire                     mailbox_irq_en,
   output logic [elink_pkg::AW-1:0] mailbox_rdata,
   output wire                     mailbox_irq
  );

   import elink_pkg::*;

   localparam int IW = $clog2(MB_DEPTH);   // index width

   logic [AW-1:0] mem [MB_DEPTH];
   logic [IW:0]   wr_ptr;                  // extra msb tells full from empty
   logic [IW:0]   rd_ptr;
   logic          empty;
   logic          full;
   logic          push;
   logic          pop;

   //##################################################
   // flags
   //##################################################
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[IW] != rd_ptr[IW]) &&
                  (wr_ptr[IW-1:0] == rd_ptr[IW-1:0]);

   assign push = mailbox_access & acc_write & ~full;     // dropped when full
   assign pop  = mailbox_access & ~acc_write & ~empty;   // empty read gives zero

   //##################################################
   // pointers
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   //##################################################
   // storage and readback
   //##################################################
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr[IW-1:0]] <= acc_data;
   end

   // oldest word, only in the cycle after a pop
   always_ff @(posedge clk)
   begin
      if (pop)
         mailbox_rdata <= mem[rd_ptr[IW-1:0]];
      else
         mailbox_rdata <= '0;
   end

   // level interrupt while words are waiting
   assign mailbox_irq = ~empty & mailbox_irq_en;

endmodule

`default_nettype wire

/* verilog/erx_cfg.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_cfg
  (
   input  wire                           clk,
   input  wire                           nreset,          // async, active low
   // config packet in
   input  wire                           cfg_access,
   input  wire elink_pkg::elink_packet_t cfg_packet,
   // raw rx debug stream
   input  wire                           rx_access,
   input  wire elink_pkg::elink_packet_t rx_packet,
   // status inputs
   input  wire [8:0]                     gpio_datain,
   input  wire [15:0]                    rx_status,
   // readback from mailbox and dma window
   input  wire [elink_pkg::AW-1:0]       mailbox_rdata,
   input  wire [elink_pkg::AW-1:0]       dma_rdata,
   // decoded access to mailbox and dma window
   output wire                           mailbox_access,
   output wire                           dma_access,
   output wire                           acc_write,
   output wire [1:0]                     acc_addr,
   output wire [elink_pkg::AW-1:0]       acc_data,
   // response packet out
   output logic                          resp_access,
   output elink_pkg::elink_packet_t      resp_packet,
   // static config
   output elink_pkg::erx_cfg_t           rx_config,
   output wire [elink_pkg::AW-1:0]       remap_base,
   output wire [44:0]                    idelay_value,
   output logic                          load_taps
  );

   import elink_pkg::*;

   egroup_e       grp;
   eblock_e       blk;
   erx_reg_e      reg_idx;
   logic          is_mmr;
   logic          is_rx_blk;
   logic          reg_access;
   logic          reg_read;
   logic          reg_write;
   logic          own_access;
   logic          own_read;
   logic          own_write;
   logic [AW-1:0] mode_q;                  // rx mode register
   logic [15:0]   status_q;
   logic [8:0]    gpio_q;
   logic [AW-1:0] offset_q;
   logic [44:0]   idelay;                  // raw tap bits
   logic [AW-1:0] testdata_q;
   logic [AW-1:0] cfg_rdata;
   elink_packet_t resp_hdr;                // data field holds pass-through data
   logic          rx_sel;
   logic          mb_sel;
   logic          dma_sel;
   logic          pass_sel;

   //##################################################
   // address decode
   //##################################################
   assign grp     = egroup_e'(cfg_packet.dstaddr[GROUP_MSB:GROUP_LSB]);
   assign blk     = eblock_e'(cfg_packet.dstaddr[BLOCK_MSB:BLOCK_LSB]);
   assign reg_idx = erx_reg_e'(cfg_packet.dstaddr[REG_MSB:REG_LSB]);

   assign is_mmr     = (grp == EGROUP_MMR);
   assign is_rx_blk  = is_mmr & (blk == EBLOCK_RX);
   assign reg_access = cfg_access & is_rx_blk & ~cfg_packet.dstaddr[MB_SEL_BIT];
   assign mailbox_access = cfg_access & is_rx_blk & cfg_packet.dstaddr[MB_SEL_BIT];
   assign dma_access = cfg_access & is_mmr & (blk == EBLOCK_DMA);

   assign own_access = reg_access | mailbox_access | dma_access;
   assign own_read   = own_access & ~cfg_packet.write;
   assign own_write  = own_access & cfg_packet.write;   // silent, no response
   assign reg_read   = reg_access & ~cfg_packet.write;
   assign reg_write  = reg_access & cfg_packet.write;

   // shared access bus to mailbox and dma window
   assign acc_write = cfg_packet.write;
   assign acc_addr  = cfg_packet.dstaddr[REG_LSB+1:REG_LSB];   // dma word select
   assign acc_data  = cfg_packet.data;

   //##################################################
   // receive registers
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mode_q   <= '0;
         status_q <= '0;
      end
      else
      begin
         if (reg_write && reg_idx == ERX_CFG)
            mode_q <= cfg_packet.data;
         if (reg_write && reg_idx == ERX_STATUS)
            status_q <= cfg_packet.data[15:0];   // write replaces sticky bits
         else
            status_q <= status_q | rx_status;    // sticky or
      end
   end

   // mode register fields out
   always_comb
   begin
      rx_config.test_mode      = mode_q[0];
      rx_config.mmu_enable     = mode_q[1];
      rx_config.remap_mode     = mode_q[3:2];
      rx_config.remap_sel      = mode_q[15:4];
      rx_config.remap_pattern  = mode_q[27:16];
      rx_config.mailbox_irq_en = mode_q[28];
   end

   always_ff @(posedge clk)
   begin
      gpio_q <= gpio_datain;                    // reads one cycle old
      if (reg_write && reg_idx == ERX_OFFSET)
         offset_q <= cfg_packet.data;
      if (reg_write && reg_idx == ERX_IDELAY0)
         idelay[31:0] <= cfg_packet.data;
      else if (reg_write && reg_idx == ERX_IDELAY1)
         idelay[44:32] <= cfg_packet.data[12:0];
      // test data accumulator
      if (reg_write && reg_idx == ERX_TESTDATA)
         testdata_q <= cfg_packet.data;
      else if (rx_access)
         testdata_q <= testdata_q + rx_packet.data;   // wraps mod 2^32
   end

   assign remap_base = offset_q;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         load_taps <= 1'b0;
      else
         load_taps <= reg_write & (reg_idx == ERX_IDELAY1);   // one cycle pulse
   end

   // nine 5-bit lanes, msb of each lane from the upper tap word
   for (genvar k = 0; k < 8; k++)
   begin : g_lane
      assign idelay_value[5*k+4:5*k] = {idelay[36+k], idelay[4*k+3:4*k]};
   end
   assign idelay_value[44:40] = {idelay[44], idelay[35:32]};   // frame lane

   //##################################################
   // readback and response
   //##################################################
   always_ff @(posedge clk)
   begin
      if (reg_read)
      begin
         case (reg_idx)
            ERX_CFG:      cfg_rdata <= mode_q;
            ERX_STATUS:   cfg_rdata <= {16'b0, status_q};
            ERX_GPIO:     cfg_rdata <= {23'b0, gpio_q};
            ERX_OFFSET:   cfg_rdata <= offset_q;
            ERX_IDELAY0:  cfg_rdata <= idelay[31:0];
            ERX_IDELAY1:  cfg_rdata <= {19'b0, idelay[44:32]};
            ERX_TESTDATA: cfg_rdata <= testdata_q;
            default:      cfg_rdata <= '0;       // unmapped index
         endcase
      end
   end

   // response header, one cycle behind the request
   always_ff @(posedge clk)
   begin
      resp_hdr.write    <= 1'b1;
      resp_hdr.datamode <= cfg_packet.datamode;
      resp_hdr.ctrlmode <= cfg_packet.ctrlmode;
      resp_hdr.dstaddr  <= own_read ? cfg_packet.srcaddr : cfg_packet.dstaddr;
      resp_hdr.srcaddr  <= cfg_packet.srcaddr;
      resp_hdr.data     <= cfg_packet.data;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         resp_access <= 1'b0;
         rx_sel      <= 1'b0;
         mb_sel      <= 1'b0;
         dma_sel     <= 1'b0;
         pass_sel    <= 1'b0;
      end
      else
      begin
         resp_access <= cfg_access & ~own_write;
         rx_sel      <= reg_read;
         mb_sel      <= mailbox_access & ~cfg_packet.write;
         dma_sel     <= dma_access & ~cfg_packet.write;
         pass_sel    <= cfg_access & ~own_access;   // not ours, echo back
      end
   end

   // one-hot data select
   always_comb
   begin
      resp_packet      = resp_hdr;
      resp_packet.data = ({AW{rx_sel}}   & cfg_rdata)
                       | ({AW{mb_sel}}   & mailbox_rdata)
                       | ({AW{dma_sel}}  & dma_rdata)
                       | ({AW{pass_sel}} & resp_hdr.data);
   end

endmodule

`default_nettype wire

/* verilog/erx_cfg_sys.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_cfg_sys
  #(
   parameter int MB_DEPTH = 4              // mailbox words
  )
  (
   input  wire                           clk,
   input  wire                           nreset,
   input  wire                           cfg_access,
   input  wire elink_pkg::elink_packet_t cfg_packet,
   input  wire                           rx_access,      // raw debug stream
   input  wire elink_pkg::elink_packet_t rx_packet,
   input  wire [8:0]                     gpio_datain,
   input  wire [15:0]                    rx_status,
   output wire                           resp_access,
   output elink_pkg::elink_packet_t      resp_packet,
   output elink_pkg::erx_cfg_t           rx_config,
   output wire [elink_pkg::AW-1:0]       remap_base,
   output wire [44:0]                    idelay_value,
   output wire                           load_taps,
   output wire                           mailbox_irq
  );

   import elink_pkg::*;

   // access bus from config block
   wire          mailbox_access;
   wire          dma_access;
   wire          acc_write;
   wire [1:0]    acc_addr;
   wire [AW-1:0] acc_data;
   // readback paths
   wire [AW-1:0] mailbox_rdata;
   wire [AW-1:0] dma_rdata;

   erx_cfg u_cfg
     (
      .clk            (clk),
      .nreset         (nreset),
      .cfg_access     (cfg_access),
      .cfg_packet     (cfg_packet),
      .rx_access      (rx_access),
      .rx_packet      (rx_packet),
      .gpio_datain    (gpio_datain),
      .rx_status      (rx_status),
      .mailbox_rdata  (mailbox_rdata),
      .dma_rdata      (dma_rdata),
      .mailbox_access (mailbox_access),
      .dma_access     (dma_access),
      .acc_write      (acc_write),
      .acc_addr       (acc_addr),
      .acc_data       (acc_data),
      .resp_access    (resp_access),
      .resp_packet    (resp_packet),
      .rx_config      (rx_config),
      .remap_base     (remap_base),
      .idelay_value   (idelay_value),
      .load_taps      (load_taps)
     );

   erx_mailbox #(.MB_DEPTH(MB_DEPTH)) u_mailbox
     (
      .clk            (clk),
      .nreset         (nreset),
      .mailbox_access (mailbox_access),
      .acc_write      (acc_write),
      .acc_data       (acc_data),
      .mailbox_irq_en (rx_config.mailbox_irq_en),   // enable from mode reg
      .mailbox_rdata  (mailbox_rdata),
      .mailbox_irq    (mailbox_irq)
     );

   erx_dma_regs u_dma
     (
      .clk        (clk),
      .nreset     (nreset),
      .dma_access (dma_access),
      .acc_write  (acc_write),
      .acc_addr   (acc_addr),
      .acc_data   (acc_data),
      .dma_rdata  (dma_rdata)
     );

endmodule

`default_nettype wire

/* verif/erx_cfg_sys_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_cfg_sys_assert
  (
   input wire                           clk,
   input wire                           nreset,
   input wire                           cfg_access,
   input wire elink_pkg::elink_packet_t cfg_packet,
   input wire                           resp_access,
   input wire                           load_taps,
   input wire                           mailbox_irq,
   input wire elink_pkg::erx_cfg_t      rx_config
  );

   import elink_pkg::*;

   int   fail_count = 0;                   // polled by the testbench
   logic mmr;
   logic rx_blk;
   logic own;
   logic answering;
   logic taps_wr;

   // request decode from the packet address
   assign mmr       = cfg_packet.dstaddr[GROUP_MSB:GROUP_LSB] == EGROUP_MMR;
   assign rx_blk    = mmr && cfg_packet.dstaddr[BLOCK_MSB:BLOCK_LSB] == EBLOCK_RX;
   assign own       = rx_blk || (mmr && cfg_packet.dstaddr[BLOCK_MSB:BLOCK_LSB] == EBLOCK_DMA);
   assign answering = cfg_access && !(cfg_packet.write && own);   // own writes stay silent
   assign taps_wr   = cfg_access && cfg_packet.write && rx_blk &&
                      cfg_packet.dstaddr[REG_MSB:REG_LSB] == ERX_IDELAY1;

   //##################################################
   // protocol checks
   //##################################################
   a_resp_timing: assert property (@(posedge clk) disable iff (!nreset)
                                   resp_access == $past(answering))
      else
      begin
         $error("resp_access does not follow the answering strobe by one cycle");
         fail_count++;
      end

   a_load_taps: assert property (@(posedge clk) disable iff (!nreset)
                                 load_taps == $past(taps_wr))
      else
      begin
         $error("load_taps does not follow the IDELAY1 write by one cycle");
         fail_count++;
      end

   // irq gated by the mode register
   a_irq_gate: assert property (@(posedge clk) disable iff (!nreset)
                                !rx_config.mailbox_irq_en |-> !mailbox_irq)
      else
      begin
         $error("mailbox_irq high while the enable is low");
         fail_count++;
      end

   a_reset_quiet: assert property (@(posedge clk)
                                   !nreset |-> !resp_access && !load_taps &&
                                               !mailbox_irq && rx_config == '0)
      else
      begin
         $error("control output active during reset");
         fail_count++;
      end

endmodule

bind erx_cfg_sys erx_cfg_sys_assert u_sva
  (
   .clk         (clk),
   .nreset      (nreset),
   .cfg_access  (cfg_access),
   .cfg_packet  (cfg_packet),
   .resp_access (resp_access),
   .load_taps   (load_taps),
   .mailbox_irq (mailbox_irq),
   .rx_config   (rx_config)
  );

`default_nettype wire

/* verif/erx_cfg_sys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module erx_cfg_sys_tb;

   import elink_pkg::*;

   localparam int         MAX_CYCLES = 2000;   // full run is about 85 cycles
   localparam logic [5:0] MB_IDX     = 6'd8;   // sets address bit 5

   logic          clk = 1'b0;
   logic          nreset;
   logic          cfg_access;
   elink_packet_t cfg_packet;
   logic          rx_access;
   elink_packet_t rx_packet;
   logic [8:0]    gpio_datain;
   logic [15:0]   rx_status;
   wire           resp_access;
   elink_packet_t resp_packet;
   erx_cfg_t      rx_config;
   wire [AW-1:0]  remap_base;
   wire [44:0]    idelay_value;
   wire           load_taps;
   wire           mailbox_irq;

   // reference model state
   logic [AW-1:0] mode_m;
   logic [15:0]   status_m;
   logic [8:0]    gpio_m;
   logic [AW-1:0] offset_m;
   logic [44:0]   idelay_m;
   logic [AW-1:0] testdata_m;
   logic [AW-1:0] dma_m [4];
   logic [AW-1:0] mb_q [$];
   elink_packet_t exp_q [$];                  // answers still owed
   string         name_q [$];
   string         test_name = "reset";
   logic [8:0]    gpio_in = '0;               // levels applied at the next drive
   logic [15:0]   status_in = '0;
   int            mb_depth;
   int            cycles = 0;

   erx_cfg_sys UUT
     (
      .clk          (clk),
      .nreset       (nreset),
      .cfg_access   (cfg_access),
      .cfg_packet   (cfg_packet),
      .rx_access    (rx_access),
      .rx_packet    (rx_packet),
      .gpio_datain  (gpio_datain),
      .rx_status    (rx_status),
      .resp_access  (resp_access),
      .resp_packet  (resp_packet),
      .rx_config    (rx_config),
      .remap_base   (remap_base),
      .idelay_value (idelay_value),
      .load_taps    (load_taps),
      .mailbox_irq  (mailbox_irq)
     );

   always #4 clk = ~clk;                      // 8 ns period

   //##################################################
   // helpers
   //##################################################
   task automatic report_failure();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input string what,
                           input logic [103:0] exp, input logic [103:0] act);
      assert (act === exp)
      else
      begin
         $display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
         report_failure();
      end
   endtask

   function automatic logic [AW-1:0] mmr_addr(input logic [2:0] blk, input logic [5:0] idx);
      return {12'h000, EGROUP_MMR, 5'b0, blk, idx, 2'b00};
   endfunction

   // nine 5-bit tap lanes, upper bit from the high tap word
   function automatic logic [44:0] tap_lanes(input logic [44:0] t);
      logic [44:0] v;
      for (int k = 0; k < 8; k++)
         v[5*k +: 5] = {t[36+k], t[4*k +: 4]};
      v[44:40] = {t[44], t[35:32]};             // frame lane
      return v;
   endfunction

   // one cycle: check levels, drive inputs, advance the model
   task automatic drive(input logic acc, input elink_packet_t pkt,
                        input logic rx_acc, input logic [AW-1:0] rx_data);
      erx_cfg_t      exp_cfg;
      elink_packet_t exp;
      logic [5:0]    idx;
      logic          mmr;
      logic          rx_reg;
      logic          mb;
      logic          dma;
      logic [AW-1:0] rd;
      @(posedge clk);
      #1;
      exp_cfg = '{test_mode: mode_m[0], mmu_enable: mode_m[1], remap_mode: mode_m[3:2],
                  remap_sel: mode_m[15:4], remap_pattern: mode_m[27:16],
                  mailbox_irq_en: mode_m[28]};
      check_eq(test_name, "rx_config", exp_cfg, rx_config);
      check_eq(test_name, "remap_base", offset_m, remap_base);
      check_eq(test_name, "idelay_value", tap_lanes(idelay_m), idelay_value);
      check_eq(test_name, "mailbox_irq", (mb_q.size() != 0) && mode_m[28], mailbox_irq);
      cfg_access     = acc;
      cfg_packet     = pkt;
      rx_access      = rx_acc;
      rx_packet.data = rx_data;
      gpio_datain    = gpio_in;
      rx_status      = status_in;
      // address decode
      idx    = pkt.dstaddr[REG_MSB:REG_LSB];
      mmr    = acc && pkt.dstaddr[GROUP_MSB:GROUP_LSB] == EGROUP_MMR;
      rx_reg = mmr && pkt.dstaddr[BLOCK_MSB:BLOCK_LSB] == EBLOCK_RX && !pkt.dstaddr[MB_SEL_BIT];
      mb     = mmr && pkt.dstaddr[BLOCK_MSB:BLOCK_LSB] == EBLOCK_RX && pkt.dstaddr[MB_SEL_BIT];
      dma    = mmr && pkt.dstaddr[BLOCK_MSB:BLOCK_LSB] == EBLOCK_DMA;
      rd = '0;                                  // unmapped reads zero
      if (rx_reg)
         case (idx)
            ERX_CFG:      rd = mode_m;
            ERX_STATUS:   rd = {16'b0, status_m};
            ERX_GPIO:     rd = {23'b0, gpio_m};
            ERX_OFFSET:   rd = offset_m;
            ERX_IDELAY0:  rd = idelay_m[31:0];
            ERX_IDELAY1:  rd = {19'b0, idelay_m[44:32]};
            ERX_TESTDATA: rd = testdata_m;
            default:      rd = '0;
         endcase
      else if (mb && mb_q.size() != 0)
         rd = mb_q[0];                          // oldest word
      else if (dma)
         rd = dma_m[pkt.dstaddr[3:2]];
      // expected answer, own writes are silent
      if (acc && !(pkt.write && (rx_reg || mb || dma)))
      begin
         exp       = pkt;
         exp.write = 1'b1;
         if (!pkt.write && (rx_reg || mb || dma))
         begin
            exp.dstaddr = pkt.srcaddr;          // read returns to sender
            exp.data    = rd;
         end
         exp_q.push_back(exp);
         name_q.push_back(test_name);
      end
      // state update at the coming edge
      if (rx_reg && pkt.write && idx == ERX_CFG)
         mode_m = pkt.data;
      if (rx_reg && pkt.write && idx == ERX_OFFSET)
         offset_m = pkt.data;
      if (rx_reg && pkt.write && idx == ERX_IDELAY0)
         idelay_m[31:0] = pkt.data;
      if (rx_reg && pkt.write && idx == ERX_IDELAY1)
         idelay_m[44:32] = pkt.data[12:0];
      if (rx_reg && pkt.write && idx == ERX_STATUS)
         status_m = pkt.data[15:0];
      else
         status_m = status_m | status_in;       // sticky
      if (rx_reg && pkt.write && idx == ERX_TESTDATA)
         testdata_m = pkt.data;
      else if (rx_acc)
         testdata_m = testdata_m + rx_data;     // mod 2^32
      if (mb && pkt.write && mb_q.size() < mb_depth)
         mb_q.push_back(pkt.data);              // full push is lost
      else if (mb && !pkt.write && mb_q.size() != 0)
         void'(mb_q.pop_front());
      if (dma && pkt.write)
         dma_m[pkt.dstaddr[3:2]] = pkt.data;
      gpio_m = gpio_in;
   endtask

   task automatic send(input logic wr, input logic [AW-1:0] addr, input logic [AW-1:0] data);
      elink_packet_t p;
      p.write    = wr;
      p.datamode = 2'($urandom);
      p.ctrlmode = 5'($urandom);
      p.dstaddr  = addr;
      p.srcaddr  = $urandom;
      p.data     = data;
      drive(1'b1, p, 1'b0, '0);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, '0, 1'b0, '0);
   endtask

   //##################################################
   // response and assertion monitors
   //##################################################
   always @(negedge clk)
   begin
      if (UUT.u_sva.fail_count != 0)
      begin
         $display("a bound assertion on the DUT ports failed");
         report_failure();
      end
      if (resp_access && exp_q.size() == 0)
      begin
         $display("response seen with no request waiting for one");
         report_failure();
      end
      else if (resp_access)
         check_eq(name_q.pop_front(), "resp_packet", exp_q.pop_front(), resp_packet);
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout, run did not end after %0d cycles", cycles);
         report_failure();
      end
   end

   //##################################################
   // stimulus
   //##################################################
   initial
   begin
      void'($urandom(96935));
      mb_depth    = UUT.MB_DEPTH;
      nreset      = 1'b1;
      cfg_access  = 1'b0;
      cfg_packet  = '0;
      rx_access   = 1'b0;
      rx_packet   = '0;
      gpio_datain = '0;
      rx_status   = '0;
      mode_m      = '0;
      status_m    = '0;
      gpio_m      = '0;
      offset_m    = 'x;                         // no reset on these
      idelay_m    = 'x;
      testdata_m  = 'x;
      for (int i = 0; i < 4; i++)
         dma_m[i] = '0;
      #1 nreset = 1'b0;
      repeat (10) @(posedge clk);
      #1 nreset = 1'b1;
      // register read after write
      test_name = "regs";
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_CFG), $urandom);
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_OFFSET), $urandom);
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_IDELAY0), $urandom);
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_IDELAY1), $urandom);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_CFG), '0);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_OFFSET), '0);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_IDELAY0), '0);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_IDELAY1), '0);
      send(1'b0, mmr_addr(EBLOCK_RX, 6'd7), '0);   // unmapped
      // sticky status and test data sum
      test_name = "status";
      status_in = 16'($urandom);
      idle(3);
      status_in = 16'($urandom);
      idle(1);
      status_in = '0;
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_STATUS), '0);
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_STATUS), $urandom);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_STATUS), '0);
      test_name = "testdata";
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_TESTDATA), $urandom);
      repeat (6) drive(1'b0, '0, 1'b1, $urandom);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_TESTDATA), '0);
      test_name = "gpio";
      gpio_in = 9'($urandom);
      idle(2);
      send(1'b0, mmr_addr(EBLOCK_RX, ERX_GPIO), '0);
      // mailbox fill, drain, irq gating
      test_name = "mailbox";
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_CFG), 32'h1000_0000);   // irq enable only
      for (int i = 0; i <= mb_depth; i++)
         send(1'b1, mmr_addr(EBLOCK_RX, MB_IDX), $urandom);      // last push dropped
      for (int i = 0; i <= mb_depth; i++)
         send(1'b0, mmr_addr(EBLOCK_RX, MB_IDX), '0);            // last read is empty
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_CFG), '0);
      send(1'b1, mmr_addr(EBLOCK_RX, MB_IDX), $urandom);
      idle(2);
      send(1'b1, mmr_addr(EBLOCK_RX, ERX_CFG), 32'h1000_0000);
      idle(2);
      send(1'b0, mmr_addr(EBLOCK_RX, MB_IDX), '0);
      // dma window, pass-through, mixed burst
      test_name = "dma";
      for (int i = 0; i < 4; i++)
         send(1'b1, mmr_addr(EBLOCK_DMA, 6'(i)), $urandom);
      for (int i = 0; i < 4; i++)
         send(1'b0, mmr_addr(EBLOCK_DMA, 6'(i)), '0);
      test_name = "passthru";
      send(1'b0, ($urandom & 32'hFFF0_FFFF) | 32'h0003_0000, $urandom);
      send(1'b1, ($urandom & 32'hFFF0_FFFF) | 32'h0007_0000, $urandom);
      test_name = "burst";
      for (int i = 0; i < 12; i++)
         if (i % 3 == 0)
            send(1'b0, mmr_addr(EBLOCK_RX, 6'(i % 8)), '0);
         else if (i % 3 == 1)
            send(1'b0, mmr_addr(EBLOCK_DMA, 6'(i % 4)), '0);
         else
            send(1'b0, ($urandom & 32'hFFF0_FFFF) | 32'h0002_0000, $urandom);
      idle(3);
      if (exp_q.size() != 0)
      begin
         $display("%0d expected responses never arrived", exp_q.size());
         report_failure();
      end
      else
      begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* erx_cfg_sys.f */
verilog/elink_pkg.sv
verilog/erx_dma_regs.sv
verilog/erx_mailbox.sv
verilog/erx_cfg.sv
verilog/erx_cfg_sys.sv
verif/erx_cfg_sys_assert.sv
verif/erx_cfg_sys_tb.sv
